/* files.f */
src/dispatch_pkg.sv
src/req_ack_initiator.sv
src/dispatch_decode.sv
src/mem_execute.sv
src/cpu_result.sv
src/cpu_dispatcher.sv
sim/cpu_dispatcher_properties.sv
sim/tb_cpu_dispatcher.sv

/* run.sh */
#!/bin/sh
# build the dispatcher testbench with Verilator, run it, then look for the pass line
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module tb_cpu_dispatcher > build.log 2>&1 &&
./obj_dir/Vtb_cpu_dispatcher > sim.log 2>&1
grep -q "=== PASS ===" sim.log && echo "simulation passed" ||
  { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* sim/cpu_dispatcher_properties.sv */
`timescale 1ns/1ps

module cpu_dispatcher_properties (
  input logic clk,
  input logic ext_rst_e,
  input logic cpu_req,
  input logic cpu_ack,
  input logic mem_req,
  input logic mem_ack,
  input logic rsp_req,
  input logic rsp_ack,
  input logic ext_bus_allow
);

  // memory request held until the memory answers
  mem_req_held: assert property (@(posedge clk) disable iff (ext_rst_e)
    mem_req && !mem_ack |=> mem_req)
    else $error("mem_req dropped before mem_ack rose");

  // response request held until the cpu answers
  rsp_req_held: assert property (@(posedge clk) disable iff (ext_rst_e)
    rsp_req && !rsp_ack |=> rsp_req)
    else $error("rsp_req dropped before rsp_ack rose");

  // no new req while the old ack is still up
  cpu_req_after_ack: assert property (@(posedge clk) disable iff (ext_rst_e)
    !cpu_req && cpu_ack |=> !cpu_req)
    else $error("cpu_req rose while cpu_ack was high");
  mem_req_after_ack: assert property (@(posedge clk) disable iff (ext_rst_e)
    !mem_req && mem_ack |=> !mem_req)
    else $error("mem_req rose while mem_ack was high");
  rsp_req_after_ack: assert property (@(posedge clk) disable iff (ext_rst_e)
    !rsp_req && rsp_ack |=> !rsp_req)
    else $error("rsp_req rose while rsp_ack was high");

  // bus grant and polling exclude each other
  grant_excludes_poll: assert property (@(posedge clk) disable iff (ext_rst_e)
    !(ext_bus_allow && cpu_req))
    else $error("ext_bus_allow and cpu_req high together");

endmodule

bind cpu_dispatcher cpu_dispatcher_properties u_props (
  .clk           (clk),
  .ext_rst_e     (ext_rst_e),
  .cpu_req       (cpu_req),
  .cpu_ack       (cpu_ack),
  .mem_req       (mem_req),
  .mem_ack       (mem_ack),
  .rsp_req       (rsp_req),
  .rsp_ack       (rsp_ack),
  .ext_bus_allow (ext_bus_allow)
);

/* sim/dispatch_golden.txt */
// msg addr data | expected cpu_new cpu_index rsp_kind rsp_data, all hex
// msg 0 none 1 start 2 end 3 read 4 write, kind 0 count 1 read 2 write, msg f ends the table
1 00000000 00000000 1 0 0 00000001
4 00000100 deadbeef 0 0 2 deadbeef
1 00000000 00000000 1 0 0 00000002
3 00000100 00000000 0 0 1 deadbeef
0 00000000 00000000 1 0 0 00000000
4 00000204 12345678 0 1 2 12345678
1 00000000 00000000 1 0 0 00000003
3 00000204 00000000 0 0 1 12345678
0 00000000 00000000 1 0 0 00000000
3 00000300 00000000 0 1 1 00000000
1 00000000 00000000 1 0 0 00000004
4 00000300 0badf00d 0 2 2 0badf00d
2 00000000 00000000 0 3 0 00000003
0 00000000 00000000 1 0 0 00000000
3 00000300 00000000 0 0 1 0badf00d
0 00000000 00000000 1 0 0 00000000
2 00000000 00000000 0 1 0 00000002
0 00000000 00000000 1 0 0 00000000
4 00000100 cafe0001 0 0 2 cafe0001
0 00000000 00000000 1 0 0 00000000
3 00000100 00000000 0 1 1 cafe0001
f 00000000 00000000 0 0 0 00000000

/* sim/tb_cpu_dispatcher.sv */
`timescale 1ns/1ps

module tb_cpu_dispatcher;
  import dispatch_pkg::*;

  localparam int CPU_QUANTITY  = 4;
  localparam int IDX_W         = 2;
  localparam int HALF_PERIOD   = 10;
  localparam int RST_CYCLES    = 4;
  localparam int WAIT_LIMIT    = 200;
  localparam int MAX_TXN       = 64;
  // transaction that first gives the bus to the outside master
  localparam int BUS_AT        = 6;
  localparam int BUS_HOLD      = 5;
  localparam logic [31:0] SEED = 32'h7066_76de;
  localparam string GOLDEN_FILE = "sim/dispatch_golden.txt";
  localparam int SIG_CPU_REQ   = 0;
  localparam int SIG_RSP_REQ   = 1;
  localparam int SIG_BUS_ALLOW = 2;

  logic clk = 1'b0;
  logic ext_rst_e;
  logic cpu_req, cpu_new, cpu_ack;
  logic [IDX_W-1:0] cpu_index;
  cpu_msg_e cpu_msg;
  logic [31:0] cpu_addr, cpu_data;
  logic mem_req, mem_we;
  logic mem_ack = 1'b0;
  logic [31:0] mem_addr, mem_wdata;
  logic [31:0] mem_rdata = '0;
  logic rsp_req, rsp_ack;
  rsp_kind_e rsp_kind;
  logic [31:0] rsp_addr, rsp_data;
  logic ext_bus_q, ext_bus_allow;

  // seven words per transaction, see the golden file header
  logic [31:0] golden [0:7*MAX_TXN-1];
  logic [31:0] mem_store [logic [31:0]];
  logic [31:0] rsp_lfsr = SEED;
  logic [31:0] mem_lfsr = SEED;
  int mem_wait = 0;
  int num_txn = 0;
  int err_value = 0;
  int err_other = 0;
  // memory port values expected for the current transaction
  logic exp_we = 1'b0;
  logic [31:0] exp_addr = '0;
  logic [31:0] exp_wdata = '0;

  always #HALF_PERIOD clk = ~clk;

  cpu_dispatcher #(
    .CPU_QUANTITY (CPU_QUANTITY),
    .IDX_W        (IDX_W)
  ) DUT (
    .clk, .ext_rst_e,
    .cpu_req, .cpu_index, .cpu_new, .cpu_ack, .cpu_msg, .cpu_addr, .cpu_data,
    .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata,
    .rsp_req, .rsp_kind, .rsp_addr, .rsp_data, .rsp_ack,
    .ext_bus_q, .ext_bus_allow
  );

  // galois lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // ack delay of 0..3 cycles, one step per bit
  task automatic draw_delay(inout logic [31:0] state, output int cycles);
    logic [1:0] bits;
    bits[0] = state[0];
    state   = lfsr_step(state);
    bits[1] = state[0];
    state   = lfsr_step(state);
    cycles  = int'(bits);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      err_value++;
    end
  endtask

  function automatic logic probe(input int which);
    case (which)
      SIG_CPU_REQ: probe = cpu_req;
      SIG_RSP_REQ: probe = rsp_req;
      default:     probe = ext_bus_allow;
    endcase
  endfunction

  // poll a level once per falling edge, bounded
  task automatic watch_signal(input int which, input logic level, output bit ok);
    int cycles;
    cycles = 0;
    while (probe(which) !== level && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    ok = (probe(which) === level);
  endtask

  task automatic report_timeout(input bit ok, input string what, input int n);
    assert (ok) else begin
      $display("timeout while waiting for %s in transaction %0d", what, n);
      err_other++;
    end
  endtask

  // memory model, ack after a random delay, reads give the last write or 0
  always @(negedge clk) begin
    if (ext_rst_e) begin
      mem_ack   = 1'b0;
      mem_rdata = '0;
      mem_wait  = 0;
    end else if (mem_req && !mem_ack) begin
      if (mem_wait > 0) begin
        mem_wait = mem_wait - 1;
      end else begin
        // port values against the polled transaction
        check_value("mem_we", 32'(mem_we), 32'(exp_we));
        check_value("mem_addr", mem_addr, exp_addr);
        if (exp_we) begin
          check_value("mem_wdata", mem_wdata, exp_wdata);
        end
        if (mem_we) begin
          mem_store[mem_addr] = mem_wdata;
        end
        mem_rdata = mem_store.exists(mem_addr) ? mem_store[mem_addr] : 32'h0;
        mem_ack   = 1'b1;
      end
    end else if (!mem_req && mem_ack) begin
      mem_ack   = 1'b0;
      mem_rdata = '0;
      draw_delay(mem_lfsr, mem_wait);
    end
  end

  // one poll as the polled cpu, plus its response if any
  task automatic run_txn(input int n, output bit ok);
    logic [31:0] g_msg, g_addr, g_data, g_new, g_idx, g_kind, g_rdata;
    int delay;
    g_msg   = golden[7*n];
    g_addr  = golden[7*n+1];
    g_data  = golden[7*n+2];
    g_new   = golden[7*n+3];
    g_idx   = golden[7*n+4];
    g_kind  = golden[7*n+5];
    g_rdata = golden[7*n+6];
    // only a write message stores to memory
    exp_we    = (g_msg[2:0] == 3'd4);
    exp_addr  = g_addr;
    exp_wdata = g_data;
    watch_signal(SIG_CPU_REQ, 1'b1, ok);
    report_timeout(ok, "cpu_req to rise", n);
    if (!ok) return;
    check_value("cpu_new", 32'(cpu_new), g_new);
    check_value("cpu_index", 32'(cpu_index), g_idx);
    draw_delay(rsp_lfsr, delay);
    repeat (delay) @(negedge clk);
    cpu_ack  = 1'b1;
    cpu_msg  = cpu_msg_e'(g_msg[2:0]);
    cpu_addr = g_addr;
    cpu_data = g_data;
    watch_signal(SIG_CPU_REQ, 1'b0, ok);
    report_timeout(ok, "cpu_req to fall", n);
    if (!ok) return;
    cpu_ack = 1'b0;
    cpu_msg = MSG_NONE;
    // a declined poll gets no response
    if (g_msg[2:0] == 3'd0) return;
    watch_signal(SIG_RSP_REQ, 1'b1, ok);
    report_timeout(ok, "rsp_req to rise", n);
    if (!ok) return;
    check_value("rsp_kind", 32'(rsp_kind), g_kind);
    // count answers carry address 0
    check_value("rsp_addr", rsp_addr, (g_kind[1:0] == 2'd0) ? 32'h0 : g_addr);
    check_value("rsp_data", rsp_data, g_rdata);
    draw_delay(rsp_lfsr, delay);
    repeat (delay) @(negedge clk);
    rsp_ack = 1'b1;
    watch_signal(SIG_RSP_REQ, 1'b0, ok);
    report_timeout(ok, "rsp_req to fall", n);
    rsp_ack = 1'b0;
  endtask

  // outside master takes the bus between two polls
  task automatic bus_grant(input int n, output bit ok);
    ext_bus_q = 1'b1;
    watch_signal(SIG_BUS_ALLOW, 1'b1, ok);
    report_timeout(ok, "ext_bus_allow to rise", n);
    if (!ok) return;
    repeat (BUS_HOLD) begin
      @(negedge clk);
      check_value("cpu_req", 32'(cpu_req), 32'h0);
      check_value("ext_bus_allow", 32'(ext_bus_allow), 32'h1);
    end
    ext_bus_q = 1'b0;
    watch_signal(SIG_BUS_ALLOW, 1'b0, ok);
    report_timeout(ok, "ext_bus_allow to fall", n);
  endtask

  initial begin
    int n;
    bit ok;
    ext_rst_e = 1'b1;
    cpu_ack   = 1'b0;
    cpu_msg   = MSG_NONE;
    cpu_addr  = '0;
    cpu_data  = '0;
    rsp_ack   = 1'b0;
    ext_bus_q = 1'b0;
    $readmemh(GOLDEN_FILE, golden);
    // table ends at the first msg f
    while (num_txn < MAX_TXN && golden[7*num_txn] !== 32'hf) begin
      num_txn++;
    end
    assert (num_txn > 0) else begin
      $display("golden file gave no transactions");
      err_other++;
    end
    repeat (RST_CYCLES) @(negedge clk);
    // control outputs quiet after reset
    check_value("cpu_req", 32'(cpu_req), 32'h0);
    check_value("mem_req", 32'(mem_req), 32'h0);
    check_value("rsp_req", 32'(rsp_req), 32'h0);
    check_value("ext_bus_allow", 32'(ext_bus_allow), 32'h0);
    check_value("op_req", 32'(DUT.op_req), 32'h0);
    check_value("res_req", 32'(DUT.res_req), 32'h0);
    check_value("done", 32'(DUT.done), 32'h0);
    ext_rst_e = 1'b0;
    ok = 1'b1;
    for (n = 0; n < num_txn && ok; n++) begin
      if (n == BUS_AT) begin
        bus_grant(n, ok);
      end
      if (ok) begin
        run_txn(n, ok);
      end
    end
    $display("errors: %0d value, %0d other, %0d transactions run", err_value, err_other, n);
    if (err_value == 0 && err_other == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* src/cpu_dispatcher.sv */
`timescale 1ns/1ps

module cpu_dispatcher #(
  parameter int CPU_QUANTITY = 4,
  parameter int IDX_W        = (CPU_QUANTITY > 1) ? $clog2(CPU_QUANTITY) : 1,
  parameter int ADDR_W       = dispatch_pkg::DEF_ADDR_W,
  parameter int DATA_W       = dispatch_pkg::DEF_DATA_W
) (
  input  logic                    clk,
  input  logic                    ext_rst_e,
  // cpu poll
  output logic                    cpu_req,
  output logic [IDX_W-1:0]        cpu_index,
  output logic                    cpu_new,
  input  logic                    cpu_ack,
  input  dispatch_pkg::cpu_msg_e  cpu_msg,
  input  logic [ADDR_W-1:0]       cpu_addr,
  input  logic [DATA_W-1:0]       cpu_data,
  // external memory
  output logic                    mem_req,
  output logic                    mem_we,
  output logic [ADDR_W-1:0]       mem_addr,
  output logic [DATA_W-1:0]       mem_wdata,
  input  logic                    mem_ack,
  input  logic [DATA_W-1:0]       mem_rdata,
  // response to the polled cpu
  output logic                    rsp_req,
  output dispatch_pkg::rsp_kind_e rsp_kind,
  output logic [ADDR_W-1:0]       rsp_addr,
  output logic [DATA_W-1:0]       rsp_data,
  input  logic                    rsp_ack,
  // outside bus master
  input  logic                    ext_bus_q,
  output logic                    ext_bus_allow
);
  import dispatch_pkg::*;

  // decode to execute
  logic              op_req;
  logic              op_ack;
  mem_op_t           op;
  // execute to result
  logic              res_req;
  logic              res_ack;
  logic              res_is_read;
  logic [ADDR_W-1:0] res_addr;
  logic [DATA_W-1:0] res_data;
  // decode to result, start and end
  logic              cnt_req;
  logic              cnt_ack;
  logic [DATA_W-1:0] cnt_value;
  // result back to decode
  logic              done;

  dispatch_decode #(
    .CPU_QUANTITY (CPU_QUANTITY),
    .IDX_W        (IDX_W)
  ) u_decode (
    .clk, .ext_rst_e,
    .cpu_req, .cpu_index, .cpu_new, .cpu_ack, .cpu_msg, .cpu_addr, .cpu_data,
    .ext_bus_q, .ext_bus_allow,
    .op_req, .op_ack, .op,
    .cnt_req, .cnt_ack, .cnt_value,
    .done
  );

  mem_execute #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_execute (
    .clk, .ext_rst_e,
    .op_req, .op, .op_ack,
    .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata,
    .res_req, .res_is_read, .res_addr, .res_data, .res_ack
  );

  cpu_result #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_result (
    .clk, .ext_rst_e,
    .res_req, .res_is_read, .res_addr, .res_data, .res_ack,
    .cnt_req, .cnt_value, .cnt_ack,
    .rsp_req, .rsp_kind, .rsp_addr, .rsp_data, .rsp_ack,
    .done
  );

endmodule

/* src/cpu_result.sv */
`timescale 1ns/1ps

module cpu_result #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                    clk,
  input  logic                    ext_rst_e,
  input  logic                    res_req,
  input  logic                    res_is_read,
  input  logic [ADDR_W-1:0]       res_addr,
  input  logic [DATA_W-1:0]       res_data,
  output logic                    res_ack,
  input  logic                    cnt_req,
  input  logic [DATA_W-1:0]       cnt_value,
  output logic                    cnt_ack,
  output logic                    rsp_req,
  output dispatch_pkg::rsp_kind_e rsp_kind,
  output logic [ADDR_W-1:0]       rsp_addr,
  output logic [DATA_W-1:0]       rsp_data,
  input  logic                    rsp_ack,
  output logic                    done
);
  import dispatch_pkg::*;

  rsp_t rec;
  rsp_t rsp_out;
  logic start;
  logic take_res;
  logic busy;
  logic rsp_done;

  // fresh requests only, not ones already acked
  assign take_res = res_req && !res_ack;
  assign start    = !busy && (take_res || (cnt_req && !cnt_ack));

  // memory result or new active count
  always_comb begin
    if (take_res) begin
      rec.kind = res_is_read ? RSP_READ : RSP_WRITE;
      rec.addr = res_addr;
      rec.data = res_data;
    end else begin
      rec.kind = RSP_COUNT;
      rec.addr = '0;
      rec.data = cnt_value;
    end
  end

  req_ack_initiator #(
    .payload_t (rsp_t)
  ) u_rsp_hs (
    .clk         (clk),
    .ext_rst_e   (ext_rst_e),
    .start       (start),
    .payload_in  (rec),
    .ack         (rsp_ack),
    .req         (rsp_req),
    .payload_out (rsp_out),
    .finished    (rsp_done)
  );

  assign rsp_kind = rsp_out.kind;
  assign rsp_addr = rsp_out.addr;
  assign rsp_data = rsp_out.data;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      busy    <= 1'b0;
      res_ack <= 1'b0;
      cnt_ack <= 1'b0;
      done    <= 1'b0;
    end else begin
      if (start) begin
        busy <= 1'b1;
      end else if (rsp_done) begin
        busy <= 1'b0;
      end
      // upstream acks
      if (start && take_res) begin
        res_ack <= 1'b1;
      end else if (!res_req) begin
        res_ack <= 1'b0;
      end
      if (start && !take_res) begin
        cnt_ack <= 1'b1;
      end else if (!cnt_req) begin
        cnt_ack <= 1'b0;
      end
      // end marker for decode
      done <= rsp_done;
    end
  end

endmodule

/* src/dispatch_decode.sv */
`timescale 1ns/1ps

module dispatch_decode #(
  parameter int CPU_QUANTITY = 4,
  parameter int IDX_W        = 2
) (
  input  logic                                clk,
  input  logic                                ext_rst_e,
  output logic                                cpu_req,
  output logic [IDX_W-1:0]                    cpu_index,
  output logic                                cpu_new,
  input  logic                                cpu_ack,
  input  dispatch_pkg::cpu_msg_e              cpu_msg,
  input  logic [dispatch_pkg::DEF_ADDR_W-1:0] cpu_addr,
  input  logic [dispatch_pkg::DEF_DATA_W-1:0] cpu_data,
  input  logic                                ext_bus_q,
  output logic                                ext_bus_allow,
  output logic                                op_req,
  input  logic                                op_ack,
  output dispatch_pkg::mem_op_t               op,
  output logic                                cnt_req,
  input  logic                                cnt_ack,
  output logic [dispatch_pkg::DEF_DATA_W-1:0] cnt_value,
  input  logic                                done
);
  import dispatch_pkg::*;

  // counts go up to CPU_QUANTITY, one bit more than an index
  localparam int CNT_W = IDX_W + 1;

  ctl_state_e       state;
  cpu_msg_e         msg_q;
  logic [CNT_W-1:0] act_cnt;
  logic [CNT_W-1:0] nact_cnt;
  logic [IDX_W-1:0] next_idx;
  // previous poll went to a nonactive cpu
  logic             last_new;
  logic             new_poll;
  logic [IDX_W-1:0] idx_use;
  logic             idx_last;

  // offer a start when cpus are waiting, every other poll
  // always offer it when nobody runs
  assign new_poll = (nact_cnt != '0 && !last_new) || act_cnt == '0;

  // an end may shrink the ring below the saved index
  assign idx_use  = ({1'b0, next_idx} >= act_cnt) ? '0 : next_idx;
  assign idx_last = ({1'b0, idx_use} >= act_cnt - 1'b1);

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state         <= CTL_POLL;
      cpu_req       <= 1'b0;
      ext_bus_allow <= 1'b0;
      op_req        <= 1'b0;
      cnt_req       <= 1'b0;
      act_cnt       <= '0;
      nact_cnt      <= CNT_W'(CPU_QUANTITY);
      next_idx      <= '0;
      last_new      <= 1'b0;
    end else begin
      case (state)
        CTL_POLL: begin
          // outside master wins over the next poll
          if (ext_bus_q) begin
            ext_bus_allow <= 1'b1;
            state         <= CTL_EXT_BUS;
          end else begin
            cpu_req  <= 1'b1;
            last_new <= new_poll;
            if (!new_poll) begin
              next_idx <= idx_last ? '0 : idx_use + 1'b1;
            end
            state <= CTL_WAIT_CPU;
          end
        end
        CTL_WAIT_CPU: begin
          if (cpu_ack) begin
            cpu_req <= 1'b0;
            state   <= CTL_ISSUE;
          end
        end
        CTL_ISSUE: begin
          // cpu has to close its ack first
          if (!cpu_ack) begin
            case (msg_q)
              MSG_READ, MSG_WRITE: begin
                op_req <= 1'b1;
                state  <= CTL_WAIT_DONE;
              end
              MSG_START: begin
                act_cnt  <= act_cnt + 1'b1;
                nact_cnt <= nact_cnt - 1'b1;
                cnt_req  <= 1'b1;
                state    <= CTL_WAIT_DONE;
              end
              MSG_END: begin
                act_cnt  <= act_cnt - 1'b1;
                nact_cnt <= nact_cnt + 1'b1;
                cnt_req  <= 1'b1;
                state    <= CTL_WAIT_DONE;
              end
              // nothing to do, straight to the next poll
              default: state <= CTL_POLL;
            endcase
          end
        end
        CTL_WAIT_DONE: begin
          if (op_req && op_ack) begin
            op_req <= 1'b0;
          end
          if (cnt_req && cnt_ack) begin
            cnt_req <= 1'b0;
          end
          // response fully closed
          if (done) begin
            state <= CTL_POLL;
          end
        end
        CTL_EXT_BUS: begin
          if (!ext_bus_q) begin
            ext_bus_allow <= 1'b0;
            state         <= CTL_POLL;
          end
        end
        default: state <= CTL_POLL;
      endcase
    end
  end

  // poll target, message capture and outgoing payloads
  always_ff @(posedge clk) begin
    if (state == CTL_POLL && !ext_bus_q) begin
      cpu_new   <= new_poll;
      cpu_index <= new_poll ? '0 : idx_use;
    end
    if (state == CTL_WAIT_CPU && cpu_ack) begin
      msg_q    <= cpu_msg;
      op.we    <= (cpu_msg == MSG_WRITE);
      op.addr  <= cpu_addr;
      op.wdata <= cpu_data;
    end
    if (state == CTL_ISSUE && !cpu_ack) begin
      // active count after this start or end
      cnt_value <= DEF_DATA_W'((msg_q == MSG_START) ? act_cnt + 1'b1 : act_cnt - 1'b1);
    end
  end

endmodule

/* src/dispatch_pkg.sv */
package dispatch_pkg;

  // default bus widths
  // the top level takes these for its ADDR_W and DATA_W
  localparam int DEF_ADDR_W = 32;
  localparam int DEF_DATA_W = 32;

  // message a polled cpu answers with
  typedef enum logic [2:0] {
    MSG_NONE  = 3'd0,
    MSG_START = 3'd1,
    MSG_END   = 3'd2,
    MSG_READ  = 3'd3,
    MSG_WRITE = 3'd4
  } cpu_msg_e;

  // kind of record sent back to the cpu
  // count is the answer to start and end
  typedef enum logic [1:0] {
    RSP_COUNT = 2'd0,
    RSP_READ  = 2'd1,
    RSP_WRITE = 2'd2
  } rsp_kind_e;

  // one memory operation, decode to execute
  typedef struct packed {
    logic                  we;
    logic [DEF_ADDR_W-1:0] addr;
    logic [DEF_DATA_W-1:0] wdata;
  } mem_op_t;

  // response record, result to cpu
  typedef struct packed {
    rsp_kind_e             kind;
    logic [DEF_ADDR_W-1:0] addr;
    logic [DEF_DATA_W-1:0] data;
  } rsp_t;

  // decode fsm states
  typedef enum logic [2:0] {
    CTL_POLL      = 3'd0,
    CTL_WAIT_CPU  = 3'd1,
    CTL_ISSUE     = 3'd2,
    CTL_WAIT_DONE = 3'd3,
    CTL_EXT_BUS   = 3'd4
  } ctl_state_e;

endpackage

/* src/mem_execute.sv */
`timescale 1ns/1ps

module mem_execute #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                  clk,
  input  logic                  ext_rst_e,
  input  logic                  op_req,
  input  dispatch_pkg::mem_op_t op,
  output logic                  op_ack,
  output logic                  mem_req,
  output logic                  mem_we,
  output logic [ADDR_W-1:0]     mem_addr,
  output logic [DATA_W-1:0]     mem_wdata,
  input  logic                  mem_ack,
  input  logic [DATA_W-1:0]     mem_rdata,
  output logic                  res_req,
  output logic                  res_is_read,
  output logic [ADDR_W-1:0]     res_addr,
  output logic [DATA_W-1:0]     res_data,
  input  logic                  res_ack
);
  import dispatch_pkg::*;

  mem_op_t           mem_op;
  logic              start;
  logic              mem_done;
  // one operation from accept until the result handshake closes
  logic              busy;
  logic              res_pend;
  logic [DATA_W-1:0] rdata_q;

  assign start = op_req && !busy;

  req_ack_initiator #(
    .payload_t (mem_op_t)
  ) u_mem_hs (
    .clk         (clk),
    .ext_rst_e   (ext_rst_e),
    .start       (start),
    .payload_in  (op),
    .ack         (mem_ack),
    .req         (mem_req),
    .payload_out (mem_op),
    .finished    (mem_done)
  );

  assign mem_we    = mem_op.we;
  assign mem_addr  = mem_op.addr;
  assign mem_wdata = mem_op.wdata;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      busy     <= 1'b0;
      op_ack   <= 1'b0;
      res_req  <= 1'b0;
      res_pend <= 1'b0;
    end else begin
      // op handshake, ack follows req back down
      if (start) begin
        busy   <= 1'b1;
        op_ack <= 1'b1;
      end else if (op_ack && !op_req) begin
        op_ack <= 1'b0;
      end
      // result goes out once memory closed its ack
      if (mem_done) begin
        res_req <= 1'b1;
      end else if (res_req && res_ack) begin
        res_req  <= 1'b0;
        res_pend <= 1'b1;
      end
      if (res_pend && !res_ack) begin
        res_pend <= 1'b0;
        busy     <= 1'b0;
      end
    end
  end

  // read data only valid under mem_ack
  always_ff @(posedge clk) begin
    if (mem_ack) begin
      rdata_q <= mem_rdata;
    end
    if (mem_done) begin
      res_is_read <= !mem_op.we;
      res_addr    <= mem_op.addr;
      // a write reports the value it stored
      res_data    <= mem_op.we ? mem_op.wdata : rdata_q;
    end
  end

endmodule

/* src/req_ack_initiator.sv */
`timescale 1ns/1ps

module req_ack_initiator #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     ext_rst_e,
  input  logic     start,
  input  payload_t payload_in,
  input  logic     ack,
  output logic     req,
  output payload_t payload_out,
  output logic     finished
);

  // second half of the handshake, req already dropped
  logic wait_low;
  // free to take a new transfer
  logic idle;

  assign idle = !req && !wait_low;

  // four-phase sequence
  // idle -> req high -> ack seen, req low -> ack low, back to idle
  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      req      <= 1'b0;
      wait_low <= 1'b0;
    end else if (idle) begin
      // start is ignored anywhere but here
      if (start) begin
        req <= 1'b1;
      end
    end else if (req) begin
      if (ack) begin
        req      <= 1'b0;
        wait_low <= 1'b1;
      end
    end else if (!ack) begin
      wait_low <= 1'b0;
    end
  end

  // payload held stable for the whole transfer
  always_ff @(posedge clk) begin
    if (idle && start) begin
      payload_out <= payload_in;
    end
  end

  // single cycle, the cycle ack is seen low again
  assign finished = wait_low && !ack;

endmodule
